//--- hw/afifo_pkg.sv
package afifo_pkg;

   // word and memory geometry
   localparam int DATA_W  = 8;
   localparam int ADDR_W  = 4;
   localparam int DEPTH   = 1 << ADDR_W;

   // pointers carry one extra wrap bit so all DEPTH slots are usable
   localparam int PTR_W   = ADDR_W + 1;

   // entry is {source tag, word}
   localparam int ENTRY_W = DATA_W + 1;

   // producer that wrote an entry and the arbiter's last-grant state
   typedef enum logic {
      SRC_A = 1'b0,
      SRC_B = 1'b1
   } src_t;

   // gray code to binary with the msb passed straight through
   function automatic logic [PTR_W-1:0] gray_to_bin(input logic [PTR_W-1:0] gray);
      logic [PTR_W-1:0] bin;
      bin[PTR_W-1] = gray[PTR_W-1];
      for (int i = PTR_W - 2; i >= 0; i--) begin
         bin[i] = gray[i] ^ bin[i+1];
      end
      return bin;
   endfunction

endpackage

//--- hw/gray_counter.sv
`timescale 1ns/100ps

module gray_counter #(
   parameter int WIDTH = 5
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             en,
   output logic [WIDTH-1:0] gray
);

   // binary count runs one step ahead of the gray image
   logic [WIDTH-1:0] bin;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bin  <= WIDTH'(1);
         gray <= '0;
      end else if (en) begin
         bin  <= bin + 1'b1;
         // gray image of the current binary count
         gray <= bin ^ (bin >> 1);
      end
   end

endmodule

//--- hw/write_arbiter.sv
`timescale 1ns/100ps

module write_arbiter (
   input  logic                            wclk,
   input  logic                            rst,
   input  logic                            req_a,
   input  logic [afifo_pkg::DATA_W-1:0]    data_a,
   input  logic                            req_b,
   input  logic [afifo_pkg::DATA_W-1:0]    data_b,
   input  logic                            full,
   output logic                            grant_a,
   output logic                            grant_b,
   output logic                            wr_en,
   output logic [afifo_pkg::ENTRY_W-1:0]   wr_data
);

   // source granted most recently
   afifo_pkg::src_t last_src;

   // winner before the full check
   afifo_pkg::src_t winner;
   logic            any_req;

   assign any_req = req_a | req_b;

   always_comb begin
      winner = afifo_pkg::SRC_A;
      if (req_a && req_b) begin
         // tie goes to whoever did not win last time
         if (last_src == afifo_pkg::SRC_A) begin
            winner = afifo_pkg::SRC_B;
         end else begin
            winner = afifo_pkg::SRC_A;
         end
      end else if (req_b) begin
         winner = afifo_pkg::SRC_B;
      end
   end

   // single-cycle grant strobes are held off while full
   always_comb begin
      grant_a = 1'b0;
      grant_b = 1'b0;
      if (any_req && !full) begin
         if (winner == afifo_pkg::SRC_A) begin
            grant_a = 1'b1;
         end else begin
            grant_b = 1'b1;
         end
      end
   end

   assign wr_en = grant_a | grant_b;

   // tag the winner's word with its source
   always_comb begin
      if (winner == afifo_pkg::SRC_B) begin
         wr_data = {afifo_pkg::SRC_B, data_b};
      end else begin
         wr_data = {afifo_pkg::SRC_A, data_a};
      end
   end

   // after reset B counts as last, so A wins the first tie
   always_ff @(posedge wclk or posedge rst) begin
      if (rst) begin
         last_src <= afifo_pkg::SRC_B;
      end else if (wr_en) begin
         last_src <= winner;
      end
   end

endmodule

//--- hw/async_fifo.sv
`timescale 1ns/100ps

module async_fifo (
   input  logic                            wclk,
   input  logic                            rclk,
   input  logic                            rst,
   input  logic                            wr_en,
   input  logic [afifo_pkg::ENTRY_W-1:0]   wr_data,
   input  logic                            read_en,
   output logic                            full,
   output logic [afifo_pkg::PTR_W-1:0]     level_w,
   output logic                            empty,
   output logic [afifo_pkg::PTR_W-1:0]     level_r,
   output logic                            rd_valid,
   output logic [afifo_pkg::DATA_W-1:0]    rd_data,
   output afifo_pkg::src_t                 rd_src
);

   // entry storage
   logic [afifo_pkg::ENTRY_W-1:0] mem [afifo_pkg::DEPTH];

   // write domain
   logic [afifo_pkg::PTR_W-1:0]   wptr_gray;
   logic [afifo_pkg::PTR_W-1:0]   wptr_bin;
   logic [afifo_pkg::PTR_W-1:0]   rptr_sync1;
   logic [afifo_pkg::PTR_W-1:0]   rptr_sync2;
   logic [afifo_pkg::ADDR_W-1:0]  waddr;

   // read domain
   logic [afifo_pkg::PTR_W-1:0]   rptr_gray;
   logic [afifo_pkg::PTR_W-1:0]   rptr_bin;
   logic [afifo_pkg::PTR_W-1:0]   wptr_sync1;
   logic [afifo_pkg::PTR_W-1:0]   wptr_sync2;
   logic [afifo_pkg::ADDR_W-1:0]  raddr;
   logic                          read_en_int;
   logic [afifo_pkg::ENTRY_W-1:0] rd_entry;

   // write side

   // write pointer advances on every accepted write
   gray_counter #(
      .WIDTH(afifo_pkg::PTR_W)
   ) u_wptr (
      .clk  (wclk),
      .rst  (rst),
      .en   (wr_en),
      .gray (wptr_gray)
   );

   assign wptr_bin = afifo_pkg::gray_to_bin(wptr_gray);
   assign waddr    = wptr_bin[afifo_pkg::ADDR_W-1:0];

   always_ff @(posedge wclk) begin
      if (wr_en) begin
         mem[waddr] <= wr_data;
      end
   end

   // two-flop sync of the read pointer into wclk
   always_ff @(posedge wclk or posedge rst) begin
      if (rst) begin
         rptr_sync1 <= '0;
         rptr_sync2 <= '0;
      end else begin
         rptr_sync1 <= rptr_gray;
         rptr_sync2 <= rptr_sync1;
      end
   end

   // wrap bit makes the difference range 0..DEPTH
   assign level_w = wptr_bin - afifo_pkg::gray_to_bin(rptr_sync2);
   assign full    = (level_w == afifo_pkg::PTR_W'(afifo_pkg::DEPTH));

   // read side

   assign read_en_int = read_en & ~empty;

   gray_counter #(
      .WIDTH(afifo_pkg::PTR_W)
   ) u_rptr (
      .clk  (rclk),
      .rst  (rst),
      .en   (read_en_int),
      .gray (rptr_gray)
   );

   assign rptr_bin = afifo_pkg::gray_to_bin(rptr_gray);
   assign raddr    = rptr_bin[afifo_pkg::ADDR_W-1:0];

   // two-flop sync of the write pointer into rclk
   always_ff @(posedge rclk or posedge rst) begin
      if (rst) begin
         wptr_sync1 <= '0;
         wptr_sync2 <= '0;
      end else begin
         wptr_sync1 <= wptr_gray;
         wptr_sync2 <= wptr_sync1;
      end
   end

   assign level_r = afifo_pkg::gray_to_bin(wptr_sync2) - rptr_bin;
   assign empty   = (level_r == '0);

   // one-cycle valid pulse after an accepted read
   always_ff @(posedge rclk or posedge rst) begin
      if (rst) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= read_en_int;
      end
   end

   // popped entry is held until the next pop
   always_ff @(posedge rclk) begin
      if (read_en_int) begin
         rd_entry <= mem[raddr];
      end
   end

   assign rd_data = rd_entry[afifo_pkg::DATA_W-1:0];
   assign rd_src  = afifo_pkg::src_t'(rd_entry[afifo_pkg::DATA_W]);

endmodule

//--- hw/afifo_top.sv
`timescale 1ns/100ps

module afifo_top (
   input  logic                            wclk,
   input  logic                            rclk,
   input  logic                            rst,
   input  logic                            req_a,
   input  logic [afifo_pkg::DATA_W-1:0]    data_a,
   input  logic                            req_b,
   input  logic [afifo_pkg::DATA_W-1:0]    data_b,
   input  logic                            read_en,
   output logic                            grant_a,
   output logic                            grant_b,
   output logic                            full,
   output logic [afifo_pkg::PTR_W-1:0]     level_w,
   output logic                            empty,
   output logic [afifo_pkg::PTR_W-1:0]     level_r,
   output logic                            rd_valid,
   output logic [afifo_pkg::DATA_W-1:0]    rd_data,
   output afifo_pkg::src_t                 rd_src
);

   // tagged write from the arbiter
   logic                            wr_en;
   logic [afifo_pkg::ENTRY_W-1:0]   wr_data;

   write_arbiter u_arb (
      .wclk    (wclk),
      .rst     (rst),
      .req_a   (req_a),
      .data_a  (data_a),
      .req_b   (req_b),
      .data_b  (data_b),
      .full    (full),
      .grant_a (grant_a),
      .grant_b (grant_b),
      .wr_en   (wr_en),
      .wr_data (wr_data)
   );

   // full goes both out and back to the arbiter
   async_fifo u_fifo (
      .wclk     (wclk),
      .rclk     (rclk),
      .rst      (rst),
      .wr_en    (wr_en),
      .wr_data  (wr_data),
      .read_en  (read_en),
      .full     (full),
      .level_w  (level_w),
      .empty    (empty),
      .level_r  (level_r),
      .rd_valid (rd_valid),
      .rd_data  (rd_data),
      .rd_src   (rd_src)
   );

endmodule

//--- verification/afifo_assert.sv
`timescale 1ns/100ps

module afifo_assert (
   input logic                          wclk,
   input logic                          rclk,
   input logic                          rst,
   input logic                          wr_en,
   input logic                          full,
   input logic                          empty,
   input logic                          read_en,
   input logic                          rd_valid,
   input logic [afifo_pkg::PTR_W-1:0]   level_w,
   input logic [afifo_pkg::PTR_W-1:0]   wptr_gray,
   input logic [afifo_pkg::PTR_W-1:0]   rptr_gray
);

   // arbiter holds writes off while full
   write_blocked_when_full: assert property (@(posedge wclk) disable iff (rst)
      !(wr_en && full)) else $error("wr_en high while full");

   // gray pointers move one bit at a time
   wptr_one_bit_step: assert property (@(posedge wclk) disable iff (rst)
      $countones(wptr_gray ^ $past(wptr_gray)) <= 1) else $error("write pointer jumped");

   rptr_one_bit_step: assert property (@(posedge rclk) disable iff (rst)
      $countones(rptr_gray ^ $past(rptr_gray)) <= 1) else $error("read pointer jumped");

   // a read on an empty fifo is dropped
   no_valid_from_empty: assert property (@(posedge rclk) disable iff (rst)
      (read_en && empty) |=> !rd_valid) else $error("rd_valid after a read while empty");

   level_in_range: assert property (@(posedge wclk) disable iff (rst)
      level_w <= afifo_pkg::PTR_W'(afifo_pkg::DEPTH)) else $error("level_w above depth");

endmodule

bind async_fifo afifo_assert u_assert (
   .wclk      (wclk),
   .rclk      (rclk),
   .rst       (rst),
   .wr_en     (wr_en),
   .full      (full),
   .empty     (empty),
   .read_en   (read_en),
   .rd_valid  (rd_valid),
   .level_w   (level_w),
   .wptr_gray (wptr_gray),
   .rptr_gray (rptr_gray)
);

//--- verification/afifo_tb.sv
`timescale 1ns/100ps

module afifo_tb;

   logic                            wclk;
   logic                            rclk;
   logic                            rst;
   logic                            req_a;
   logic [afifo_pkg::DATA_W-1:0]    data_a;
   logic                            req_b;
   logic [afifo_pkg::DATA_W-1:0]    data_b;
   logic                            read_en;
   logic                            grant_a;
   logic                            grant_b;
   logic                            full;
   logic [afifo_pkg::PTR_W-1:0]     level_w;
   logic                            empty;
   logic [afifo_pkg::PTR_W-1:0]     level_r;
   logic                            rd_valid;
   logic [afifo_pkg::DATA_W-1:0]    rd_data;
   afifo_pkg::src_t                 rd_src;

   // reference queue of {tag, word} in write order
   logic [afifo_pkg::ENTRY_W-1:0]   model_q[$];
   afifo_pkg::src_t                 last_src;
   int                              errors;
   int                              wr_count;
   // pops accepted on the read side
   int                              rd_count;
   // rd_count seen at the last three wclk edges
   int                              rd_hist[3];
   int                              req_pct;
   int                              rd_pct;
   logic                            running;
   logic                            stop_req;
   logic                            fill_only;
   logic                            saw_full;
   logic                            expect_valid;

   afifo_top DUT (
      .wclk     (wclk),
      .rclk     (rclk),
      .rst      (rst),
      .req_a    (req_a),
      .data_a   (data_a),
      .req_b    (req_b),
      .data_b   (data_b),
      .read_en  (read_en),
      .grant_a  (grant_a),
      .grant_b  (grant_b),
      .full     (full),
      .level_w  (level_w),
      .empty    (empty),
      .level_r  (level_r),
      .rd_valid (rd_valid),
      .rd_data  (rd_data),
      .rd_src   (rd_src)
   );

   initial begin
      wclk = 1'b0;
      forever #50 wclk = ~wclk;
   end

   initial begin
      rclk = 1'b0;
      forever #65 rclk = ~rclk;
   end

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("FAILED %s expected %h actual %h at %0t", name, expected, actual, $time);
      errors++;
   endtask

   task automatic report_problem(input string msg);
      $display("error: %s at %0t", msg, $time);
      errors++;
   endtask

   task automatic check_reset_state();
      if (grant_a !== 1'b0 || grant_b !== 1'b0)
         report_problem("a grant is high at the end of reset");
      if (rd_valid !== 1'b0)
         report_mismatch("rd_valid", 32'h0, 32'(rd_valid));
      if (empty !== 1'b1)
         report_mismatch("empty", 32'h1, 32'(empty));
      if (full !== 1'b0)
         report_mismatch("full", 32'h0, 32'(full));
      if (level_w !== '0)
         report_mismatch("level_w", 32'h0, 32'(level_w));
      if (level_r !== '0)
         report_mismatch("level_r", 32'h0, 32'(level_r));
   endtask

   // grant rules, levels, model push and producer stimulus
   always @(posedge wclk) begin
      int upper;
      int lower;
      if (running) begin
         if (full)
            saw_full = 1'b1;
         if (grant_a && grant_b)
            report_problem("both grants high in one cycle");
         if ((grant_a && !req_a) || (grant_b && !req_b))
            report_problem("grant without a request");
         if ((grant_a || grant_b) && full)
            report_problem("grant given while full");
         if ((req_a || req_b) && !full && !grant_a && !grant_b)
            report_problem("request not granted while not full");
         // tie goes to the source not granted last
         if (req_a && req_b && (grant_a || grant_b) &&
             grant_a !== (last_src == afifo_pkg::SRC_B))
            report_mismatch("grant_a", 32'(last_src == afifo_pkg::SRC_B), 32'(grant_a));
         if (fill_only && wr_count >= afifo_pkg::DEPTH && full !== 1'b1)
            report_mismatch("full", 32'h1, 32'(full));
         // pops reach the write side two to three edges late
         upper = wr_count - rd_hist[2];
         if (upper > afifo_pkg::DEPTH)
            upper = afifo_pkg::DEPTH;
         lower = wr_count - rd_count;
         if (int'(level_w) > upper)
            report_mismatch("level_w", 32'(upper), 32'(level_w));
         if (int'(level_w) < lower)
            report_mismatch("level_w", 32'(lower), 32'(level_w));
         if (grant_a) begin
            model_q.push_back({afifo_pkg::SRC_A, data_a});
            last_src = afifo_pkg::SRC_A;
            wr_count++;
         end
         if (grant_b) begin
            model_q.push_back({afifo_pkg::SRC_B, data_b});
            last_src = afifo_pkg::SRC_B;
            wr_count++;
         end
         rd_hist[2] = rd_hist[1];
         rd_hist[1] = rd_hist[0];
         rd_hist[0] = rd_count;
         // a producer holds its word until granted
         if (grant_a || !req_a) begin
            req_a  <= !stop_req && (int'($urandom_range(99)) < req_pct);
            data_a <= 8'($urandom);
         end
         if (grant_b || !req_b) begin
            req_b  <= !stop_req && (int'($urandom_range(99)) < req_pct);
            data_b <= 8'($urandom);
         end
      end
   end

   // valid pulse, data compare and consumer stimulus
   always @(posedge rclk) begin
      logic [afifo_pkg::ENTRY_W-1:0] head;
      if (running) begin
         if (rd_valid !== expect_valid)
            report_mismatch("rd_valid", 32'(expect_valid), 32'(rd_valid));
         if (rd_valid) begin
            if (model_q.size() == 0) begin
               report_problem("rd_valid with nothing left in the model");
            end else begin
               head = model_q.pop_front();
               if (rd_src !== head[afifo_pkg::DATA_W])
                  report_mismatch("rd_src", 32'(head[afifo_pkg::DATA_W]), 32'(rd_src));
               if (rd_data !== head[afifo_pkg::DATA_W-1:0])
                  report_mismatch("rd_data", 32'(head[afifo_pkg::DATA_W-1:0]), 32'(rd_data));
            end
         end
         // the read side never sees more than was written and not yet popped
         if (int'(level_r) > wr_count - rd_count)
            report_mismatch("level_r", 32'(wr_count - rd_count), 32'(level_r));
         expect_valid = read_en && !empty;
         if (read_en && !empty)
            rd_count++;
         read_en <= (int'($urandom_range(99)) < rd_pct);
      end
   end

   initial begin
      void'($urandom(32'h60da_1d7a));
      errors       = 0;
      wr_count     = 0;
      rd_count     = 0;
      rd_hist      = '{0, 0, 0};
      last_src     = afifo_pkg::SRC_B;
      saw_full     = 1'b0;
      expect_valid = 1'b0;
      rst          = 1'b1;
      req_a        = 1'b0;
      data_a       = '0;
      req_b        = 1'b0;
      data_b       = '0;
      read_en      = 1'b0;
      running      = 1'b0;
      stop_req     = 1'b0;
      fill_only    = 1'b1;
      req_pct      = 0;
      rd_pct       = 0;
      repeat (4) @(posedge wclk);
      check_reset_state();
      rst     <= 1'b0;
      running <= 1'b1;
      // fill with no reads until full
      req_pct <= 90;
      repeat (50) @(posedge wclk);
      fill_only <= 1'b0;
      req_pct   <= 0;
      rd_pct    <= 90;
      repeat (70) @(posedge wclk);
      // alternate heavy writing and heavy reading
      for (int i = 0; i < 3; i++) begin
         req_pct <= 90;
         rd_pct  <= 30;
         repeat (80) @(posedge wclk);
         req_pct <= 20;
         rd_pct  <= 90;
         repeat (80) @(posedge wclk);
      end
      // drain everything including held words
      stop_req <= 1'b1;
      rd_pct   <= 100;
      while (req_a || req_b || model_q.size() != 0)
         @(posedge wclk);
      repeat (4) @(posedge rclk);
      if (empty !== 1'b1)
         report_mismatch("empty", 32'h1, 32'(empty));
      // keep reading while empty
      repeat (10) @(posedge rclk);
      if (level_w !== '0)
         report_mismatch("level_w", 32'h0, 32'(level_w));
      if (!saw_full)
         report_problem("full was never reached");
      $display("writes %0d, reads %0d, errors %0d", wr_count, rd_count, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   // four times the 600-cycle test length
   initial begin
      #(600 * 100 * 4);
      $display("timeout: the run did not complete in %0d ns", 600 * 100 * 4);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

//--- files.f
hw/afifo_pkg.sv
hw/gray_counter.sv
hw/write_arbiter.sv
hw/async_fifo.sv
hw/afifo_top.sv
verification/afifo_assert.sv
verification/afifo_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the async FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal -f files.f \
   --top-module afifo_tb -o afifo_sim > compile.log 2>&1 \
   && ./obj_dir/afifo_sim > sim.log 2>&1 \
   || { echo "compile or run failed, see compile.log and sim.log"; exit 1; }

grep -qx "Simulation finished: PASS" sim.log \
   && { echo "result: pass"; exit 0; } \
   || { echo "result: fail, see sim.log"; exit 1; }
